// File: bcd_pkg.sv
package bcd_pkg;

  // Binary sample width
  localparam int bin_width = 16;

  // Decimal digits needed for the largest 16-bit value, 65535
  localparam int bcd_digits = 5;

  // Bits per packed BCD digit
  localparam int digit_width = 4;

  // Packed BCD result, one nibble per digit
  localparam int bcd_width = bcd_digits * digit_width;

  // Sequence tag, wraps at 256
  localparam int tag_width = 8;

  // Pipeline depth and the rounds each stage does
  localparam int num_stages = 4;
  localparam int rounds_per_stage = 4;

  // Egress queue slots, also the producer's starting credit count
  localparam int queue_depth = 4;
  localparam int queue_ptr_width = $clog2(queue_depth);

  // Downstream credit counter width, saturates at all ones
  localparam int credit_width = 16;

  // Double-dabble working word: digit field above the binary field
  localparam int scratch_width = bcd_width + bin_width;

  // Word handed from stage to stage, valid rides along
  typedef struct packed {
    logic                     valid;
    logic [tag_width-1:0]     tag;
    logic [scratch_width-1:0] scratch;
  } scratch_t;

  // Queued and delivered result
  typedef struct packed {
    logic [tag_width-1:0] tag;
    logic [bcd_width-1:0] bcd;
  } result_t;

endpackage

// File: bcd_ingress.sv
`timescale 1ns/1ns

module bcd_ingress (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid,
  input  logic [bcd_pkg::bin_width-1:0] in_data,
  output bcd_pkg::scratch_t          stage_out
);

  import bcd_pkg::*;

  // Tag for the next accepted sample
  logic [tag_width-1:0] tag_cnt;

  // Initial scratch word, digits cleared and binary in the low bits
  logic [scratch_width-1:0] init_scratch;

  assign init_scratch = {{bcd_width{1'b0}}, in_data};

  // Sequence counter, one step per accepted sample
  always_ff @(posedge clk) begin
    if (rst) begin
      tag_cnt <= '0;
    end else if (in_valid) begin
      // Natural wrap from 255 back to 0
      tag_cnt <= tag_cnt + 1'b1;
    end
  end

  // Valid bit is control state
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_out.valid <= 1'b0;
    end else begin
      stage_out.valid <= in_valid;
    end
  end

  // Payload only loads on an accepted sample
  always_ff @(posedge clk) begin
    if (in_valid) begin
      stage_out.tag     <= tag_cnt;
      stage_out.scratch <= init_scratch;
    end
  end

endmodule

// File: dabble_stage.sv
`timescale 1ns/1ns

module dabble_stage (
  input  logic              clk,
  input  logic              rst,
  input  bcd_pkg::scratch_t stage_in,
  output bcd_pkg::scratch_t stage_out
);

  import bcd_pkg::*;

  // Scratch word before each round, last entry is the stage result
  logic [scratch_width-1:0] round_word [rounds_per_stage+1];

  assign round_word[0] = stage_in.scratch;

  for (genvar r = 0; r < rounds_per_stage; r++) begin : g_round
    // Word after the add-three step of this round
    logic [scratch_width-1:0] adjusted;

    for (genvar d = 0; d < bcd_digits; d++) begin : g_digit
      logic [digit_width-1:0] digit;

      // Pick digit d out of the BCD field
      assign digit = round_word[r][bin_width + digit_width*d +: digit_width];

      // Five or more would pass ten after the shift, so correct it now
      assign adjusted[bin_width + digit_width*d +: digit_width] =
        (digit >= 4'd5) ? digit + 4'd3 : digit;
    end

    // Binary field is untouched by the correction
    assign adjusted[bin_width-1:0] = round_word[r][bin_width-1:0];

    // Shift one binary bit up into the digit field
    // The top bit drops off, it is always zero for 16-bit input
    assign round_word[r+1] = {adjusted[scratch_width-2:0], 1'b0};
  end

  // Stage register, valid cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_out.valid <= 1'b0;
    end else begin
      stage_out.valid <= stage_in.valid;
    end
  end

  // Tag and scratch follow the data, no reset needed
  always_ff @(posedge clk) begin
    if (stage_in.valid) begin
      stage_out.tag     <= stage_in.tag;
      stage_out.scratch <= round_word[rounds_per_stage];
    end
  end

endmodule

// File: bcd_egress.sv
`timescale 1ns/1ns

module bcd_egress (
  input  logic              clk,
  input  logic              rst,
  input  bcd_pkg::scratch_t stage_in,
  input  logic              out_credit,
  output logic              out_valid,
  output bcd_pkg::result_t  out_data,
  output logic              in_credit
);

  import bcd_pkg::*;

  // Result queue storage
  result_t queue_mem [queue_depth];

  // Queue pointers, depth is a power of two so they wrap on their own
  logic [queue_ptr_width-1:0] wr_ptr;
  logic [queue_ptr_width-1:0] rd_ptr;

  // Entries held, needs one bit more than the pointers
  logic [queue_ptr_width:0] count;

  // Credits granted by the consumer and not yet used
  logic [credit_width-1:0] credit_cnt;

  logic    push;
  logic    pop;
  logic    empty;
  result_t push_data;

  // Last stage result enters the queue unconditionally
  // Upstream credits keep the queue from overflowing
  assign push = stage_in.valid;

  // Digit field sits above the now-empty binary field
  assign push_data.tag = stage_in.tag;
  assign push_data.bcd = stage_in.scratch[bin_width +: bcd_width];

  assign empty = (count == '0);

  // Send one result when data and a credit are both present
  assign pop = !empty && (credit_cnt != '0);

  // Queue write, storage has no reset
  always_ff @(posedge clk) begin
    if (push) begin
      queue_mem[wr_ptr] <= push_data;
    end
  end

  // Pointer and occupancy tracking
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Downstream credit counter
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= '0;
    end else begin
      case ({out_credit, pop})
        2'b10: begin
          // Hold at the top rather than wrap to zero
          if (credit_cnt != '1) begin
            credit_cnt <= credit_cnt + 1'b1;
          end
        end
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Output strobe and upstream credit return
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      out_valid <= pop;
      // Slot is free again one cycle after the result leaves
      in_credit <= out_valid;
    end
  end

  // Output data register, loads only on a pop
  always_ff @(posedge clk) begin
    if (pop) begin
      out_data <= queue_mem[rd_ptr];
    end
  end

endmodule

// File: bcd_pipeline_top.sv
`timescale 1ns/1ns

module bcd_pipeline_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  logic [bcd_pkg::bin_width-1:0] in_data,
  output logic                          in_credit,
  input  logic                          out_credit,
  output logic                          out_valid,
  output bcd_pkg::result_t              out_data
);

  import bcd_pkg::*;

  // Entry 0 from ingress, entry k+1 from stage k, last one into egress
  scratch_t stage_bus [num_stages+1];

  // Sample register and tag
  bcd_ingress u_bcd_ingress (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .stage_out (stage_bus[0])
  );

  // Four rounds per stage, sixteen in total
  for (genvar k = 0; k < num_stages; k++) begin : g_stage
    dabble_stage u_dabble_stage (
      .clk       (clk),
      .rst       (rst),
      .stage_in  (stage_bus[k]),
      .stage_out (stage_bus[k+1])
    );
  end

  // Queue, consumer credits and producer credit return
  bcd_egress u_bcd_egress (
    .clk        (clk),
    .rst        (rst),
    .stage_in   (stage_bus[num_stages]),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .in_credit  (in_credit)
  );

endmodule

// File: tb_bcd_sva.sv
`timescale 1ns/1ns

module tb_bcd_sva (
  input logic                                clk,
  input logic                                rst,
  input logic                                push,
  input logic                                pop,
  input logic [bcd_pkg::queue_ptr_width:0]   count,
  input logic                                out_credit,
  input logic                                out_valid,
  input logic                                in_credit
);

  import bcd_pkg::*;

  // Consumer credits granted and not yet spent, counted from the port events
  int unsigned credit_balance;

  always_ff @(posedge clk) begin
    if (rst) begin
      credit_balance <= 0;
    end else begin
      credit_balance <= credit_balance + out_credit - pop;
    end
  end

  // Upstream credits must keep the last stage from writing a full queue
  a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    push |-> (count != queue_depth))
    else $error("egress queue written while full");

  // A result leaves only when a consumer credit was held in the pop cycle
  a_valid_needs_credit: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> ($past(credit_balance) != 0))
    else $error("out_valid raised with no consumer credit");

  // Credit return follows an output by exactly one cycle
  a_credit_after_output: assert property (@(posedge clk) disable iff (rst)
    in_credit |-> $past(out_valid))
    else $error("in_credit pulsed without an output in the cycle before");

endmodule

// Attach to every egress block in the design
bind bcd_egress tb_bcd_sva u_tb_bcd_sva (
  .clk        (clk),
  .rst        (rst),
  .push       (push),
  .pop        (pop),
  .count      (count),
  .out_credit (out_credit),
  .out_valid  (out_valid),
  .in_credit  (in_credit)
);

// File: tb_bcd_checker.sv
`timescale 1ns/1ns

module tb_bcd_checker (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  logic [bcd_pkg::bin_width-1:0] in_data,
  input  logic                          out_credit,
  input  logic                          out_valid,
  input  bcd_pkg::result_t              out_data,
  input  logic                          in_credit,
  output int                            error_count,
  output int                            out_count,
  output int                            return_count,
  output int                            pending
);

  import bcd_pkg::*;

  // Accepted samples and their expected tags, oldest first
  logic [bin_width-1:0] sample_q [$];
  logic [tag_width-1:0] tag_q [$];
  logic [tag_width-1:0] next_tag;
  int                   grant_count;

  // Reference model, peel off decimal digits by division
  function automatic logic [bcd_width-1:0] decimal_digits(input logic [bin_width-1:0] value);
    logic [bcd_width-1:0] digits;
    int unsigned          rest;
    digits = '0;
    rest = value;
    for (int d = 0; d < bcd_digits; d++) begin
      digits[digit_width*d +: digit_width] = 4'(rest % 10);
      rest = rest / 10;
    end
    return digits;
  endfunction

  always @(posedge clk) begin
    logic [bin_width-1:0] sample;
    logic [tag_width-1:0] tag;
    logic [bcd_width-1:0] expected;
    if (rst) begin
      sample_q.delete();
      tag_q.delete();
      next_tag = '0;
      grant_count = 0;
      out_count = 0;
      return_count = 0;
      error_count = 0;
    end else begin
      if (in_valid) begin
        sample_q.push_back(in_data);
        tag_q.push_back(next_tag);
        // Tag wraps at 256 like the DUT counter
        next_tag = next_tag + 1'b1;
      end
      if (out_valid) begin
        out_count++;
        // Grants counted so far only, this cycle's grant comes too late
        if (out_count > grant_count) begin
          $display("Output at %0t was sent without a consumer credit", $time);
          error_count++;
        end
        if (sample_q.size() == 0) begin
          $display("Output at %0t has no pending sample, result duplicated", $time);
          error_count++;
        end else begin
          sample = sample_q.pop_front();
          tag = tag_q.pop_front();
          expected = decimal_digits(sample);
          if (out_data.bcd !== expected) begin
            $display("[FAIL] t=%0t out_data.bcd got %05h expected %05h (sample %0d)",
                     $time, out_data.bcd, expected, sample);
            error_count++;
          end
          if (out_data.tag !== tag) begin
            $display("[FAIL] t=%0t out_data.tag got %0d expected %0d",
                     $time, out_data.tag, tag);
            error_count++;
          end
        end
      end
      if (out_credit) begin
        grant_count++;
      end
      if (in_credit) begin
        return_count++;
      end
    end
    pending = sample_q.size();
  end

endmodule

// File: tb_bcd_pipeline.sv
`timescale 1ns/1ns

module tb_bcd_pipeline;

  import bcd_pkg::*;

  localparam int num_samples = 400;
  // Twenty cycles per sample plus slack for fill and drain
  localparam int cycle_limit = num_samples * 20 + 200;
  // Consumer credits withheld for this many cycles after reset
  localparam int hold_cycles = 40;

  logic                 clk;
  logic                 rst;
  logic                 in_valid;
  logic [bin_width-1:0] in_data;
  logic                 in_credit;
  logic                 out_credit;
  logic                 out_valid;
  result_t              out_data;

  int checker_errors;
  int out_count;
  int return_count;
  int pending;

  logic [31:0]          lfsr_state;
  logic [bin_width-1:0] corner [4];
  int                   credits;
  int                   sent;
  int                   cycles;
  int                   tb_errors;

  bcd_pipeline_top u_bcd_pipeline_top (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

  tb_bcd_checker u_tb_bcd_checker (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_data      (in_data),
    .out_credit   (out_credit),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .in_credit    (in_credit),
    .error_count  (checker_errors),
    .out_count    (out_count),
    .return_count (return_count),
    .pending      (pending)
  );

  // 10 ns period
  always #5 clk = ~clk;

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit, first bit ends up in the MSB
  task automatic take_bits(input int n, output logic [bin_width-1:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[bin_width-2:0], lfsr_state[0]};
    end
  endtask

  initial begin
    logic [bin_width-1:0] bits;
    logic                 done;
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_credit = 1'b0;
    lfsr_state = 32'ha430e5ef;
    corner[0] = 16'd0;
    corner[1] = 16'd65535;
    corner[2] = 16'd9999;
    corner[3] = 16'd10000;
    credits = queue_depth;
    sent = 0;
    cycles = 0;
    tb_errors = 0;
    done = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    while (!done && cycles < cycle_limit) begin
      cycles++;
      // Slot freed in the queue
      if (in_credit) begin
        credits++;
      end
      in_valid = 1'b0;
      take_bits(1, bits);
      if (credits > 0 && sent < num_samples && bits[0]) begin
        if (sent < 4) begin
          in_data = corner[sent];
        end else begin
          take_bits(bin_width, in_data);
        end
        in_valid = 1'b1;
        credits--;
        sent++;
      end
      if (credits < 0 || credits > queue_depth) begin
        $display("Producer credit count out of range (%0d) at %0t", credits, $time);
        tb_errors++;
      end
      // Consumer grants start after the hold phase
      out_credit = 1'b0;
      if (cycles > hold_cycles) begin
        take_bits(1, bits);
        out_credit = bits[0];
      end
      if (cycles == hold_cycles && out_count != 0) begin
        $display("Results delivered while consumer credits were withheld");
        tb_errors++;
      end
      @(negedge clk);
      done = (sent == num_samples) && (out_count == num_samples) &&
             (return_count == num_samples);
    end
    in_valid = 1'b0;
    out_credit = 1'b0;
    if (!done) begin
      $display("Timeout after %0d cycles with %0d of %0d results delivered",
               cycles, out_count, num_samples);
      tb_errors++;
    end
    // Idle cycles catch stray or duplicated outputs
    repeat (10) @(negedge clk);
    if (pending != 0) begin
      $display("%0d samples never produced a result", pending);
      tb_errors++;
    end
    if (return_count != out_count) begin
      $display("Credit returns (%0d) differ from outputs (%0d)", return_count, out_count);
      tb_errors++;
    end
    if (credits != queue_depth) begin
      $display("Producer ended with %0d credits instead of %0d", credits, queue_depth);
      tb_errors++;
    end
    $display("Errors: checker %0d, testbench %0d, results %0d of %0d",
             checker_errors, tb_errors, out_count, num_samples);
    if (checker_errors == 0 && tb_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
bcd_pkg.sv
bcd_ingress.sv
dabble_stage.sv
bcd_egress.sv
bcd_pipeline_top.sv
tb_bcd_sva.sv
tb_bcd_checker.sv
tb_bcd_pipeline.sv

// File: run.sh
#!/bin/sh
# Build and run the BCD pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_bcd_pipeline \
  -f project.f \
  -o Vtb_bcd_pipeline

# Keep a log so the result can be searched
./obj_dir/Vtb_bcd_pipeline | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
